//--- list.f
verilog/axi_lite_pkg.sv
verilog/slave_fanout.sv
verilog/read_return.sv
verilog/master_arbiter.sv
verilog/axi_lite_interconnect.sv
verification/interconnect_props.sv
verification/tb_axi_lite_interconnect.sv

//--- run.sh
#!/bin/sh
# build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f list.f \
    --top-module tb_axi_lite_interconnect -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- verification/tb_axi_lite_interconnect.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_lite_interconnect;
    import axi_lite_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 2000;
    localparam int SEED         = 40;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES + 100) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    wr_req_t    m0_wr;
    logic       m0_awvalid;
    logic       m0_awready;
    logic       m0_wvalid;
    logic       m0_wready;
    rd_req_t    m0_ar;
    logic       m0_arvalid;
    logic       m0_arready;
    data_t      m0_rdata;
    logic       m0_rvalid;
    logic       m0_rready;
    wr_req_t    m1_wr;
    logic       m1_awvalid;
    logic       m1_awready;
    logic       m1_wvalid;
    logic       m1_wready;
    rd_req_t    m1_ar;
    logic       m1_arvalid;
    logic       m1_arready;
    data_t      m1_rdata;
    logic       m1_rvalid;
    logic       m1_rready;
    wr_req_t    s_wr_req [SLAVE_COUNT];
    slave_sel_t s_wr_valid;
    slave_sel_t s_wr_ready;
    rd_req_t    s_ar_req [SLAVE_COUNT];
    slave_sel_t s_arvalid;
    slave_sel_t s_arready;
    data_t      s_rdata [SLAVE_COUNT];
    slave_sel_t s_rvalid;
    slave_sel_t s_rready;

    integer seed;
    logic   m0_wr_done = 1'b0;  // handshakes seen at the last edge
    logic   m1_wr_done = 1'b0;
    logic   ar_done    = 1'b0;
    logic   rd_done    = 1'b0;
    logic   sl_acc     = 1'b0;
    logic   sl_done    = 1'b0;
    int     acc_idx    = 0;
    addr_t  acc_addr   = '0;
    logic   rd_out     = 1'b0;  // one read in flight
    logic   sl_busy    = 1'b0;
    int     sl_idx     = 0;
    addr_t  sl_addr    = '0;
    int     sl_wait    = 0;
    int     n_reset    = 0;
    int     n_write    = 0;
    int     n_wr_prio  = 0;
    int     n_ar_prio  = 0;
    int     n_wr_bp    = 0;
    int     n_ar_bp    = 0;
    int     n_read     = 0;
    int     missing    = 0;

    axi_lite_interconnect uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic wr_req_t random_write();
        wr_req_t w;
        w.addr = $random(seed);
        w.data = $random(seed);
        w.strb = strb_t'($random(seed));
        return w;
    endfunction

    task automatic drive_masters();
        if (m0_wr_done) begin
            m0_awvalid = 1'b0;
            m0_wvalid  = 1'b0;
        end
        if (m1_wr_done) begin
            m1_awvalid = 1'b0;
            m1_wvalid  = 1'b0;
        end
        if (!m0_awvalid && ($random(seed) & 3) == 0) begin
            m0_wr      = random_write();
            m0_awvalid = 1'b1;
            m0_wvalid  = 1'b1;
        end
        if (!m1_awvalid && ($random(seed) & 3) == 0) begin
            m1_wr      = random_write();
            m1_awvalid = 1'b1;
            m1_wvalid  = 1'b1;
        end
        if (ar_done)
            rd_out = 1'b1;
        if (rd_done)
            rd_out = 1'b0;
        if (rd_out) begin
            m0_arvalid = 1'b0;  // the loser gives up while a read is in flight
            m1_arvalid = 1'b0;
        end else begin
            if (!m0_arvalid && ($random(seed) & 7) == 0) begin
                m0_ar.addr = $random(seed);
                m0_arvalid = 1'b1;
            end
            if (!m1_arvalid && ($random(seed) & 7) == 0) begin
                m1_ar.addr = $random(seed);
                m1_arvalid = 1'b1;
            end
        end
        m0_rready = ($random(seed) & 1) != 0;
        m1_rready = ($random(seed) & 1) != 0;
    endtask

    task automatic drive_slaves();
        s_wr_ready = slave_sel_t'($random(seed));
        s_arready  = slave_sel_t'($random(seed));
        s_rvalid   = '0;
        for (int i = 0; i < SLAVE_COUNT; i++)
            s_rdata[i] = $random(seed);  // noise on slaves that owe nothing
        if (sl_done)
            sl_busy = 1'b0;
        if (sl_acc) begin
            sl_busy = 1'b1;
            sl_idx  = acc_idx;
            sl_addr = acc_addr;
            sl_wait = $unsigned($random(seed)) % 3;  // answer 1 to 3 cycles later
        end
        if (sl_busy) begin
            if (sl_wait > 0) begin
                sl_wait--;
            end else begin
                s_rvalid[sl_idx] = 1'b1;
                s_rdata[sl_idx]  = ~sl_addr;
            end
        end
    endtask

    task automatic check_reached(input string what, input int count);
        if (count == 0) begin
            $display("behavior never reached: %s", what);
            missing++;
        end
    endtask

    // values here equal those at the next rising edge
    always @(negedge clk) begin
        addr_t win_addr;
        m0_wr_done = m0_awvalid & m0_wvalid & m0_awready & m0_wready;
        m1_wr_done = m1_awvalid & m1_wvalid & m1_awready & m1_wready;
        ar_done    = (m0_arvalid & m0_arready) | (m1_arvalid & m1_arready);
        rd_done    = (m0_rvalid & m0_rready) | (m1_rvalid & m1_rready);
        sl_done    = sl_busy && s_rvalid[sl_idx] && s_rready[sl_idx];
        sl_acc     = 1'b0;
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            if (s_arvalid[i] && s_arready[i]) begin
                sl_acc   = 1'b1;
                acc_idx  = i;
                acc_addr = s_ar_req[i].addr;
            end
        end
        if (!rst_n) begin
            n_reset++;
        end else begin
            win_addr = (m0_awvalid && m0_wvalid) ? m0_wr.addr : m1_wr.addr;
            if ((m0_awvalid && m0_wvalid) || (m1_awvalid && m1_wvalid)) begin
                n_write++;
                if (!s_wr_ready[win_addr[SEL_LSB +: $clog2(SLAVE_COUNT)]])
                    n_wr_bp++;
            end
            if (m0_awvalid && m0_wvalid && m1_awvalid && m1_wvalid)
                n_wr_prio++;
            win_addr = m0_arvalid ? m0_ar.addr : m1_ar.addr;
            if ((m0_arvalid || m1_arvalid) &&
                !s_arready[win_addr[SEL_LSB +: $clog2(SLAVE_COUNT)]])
                n_ar_bp++;
            if (m0_arvalid && m1_arvalid)
                n_ar_prio++;
            if (m0_rvalid || m1_rvalid)
                n_read++;
        end
    end

    initial begin
        seed       = SEED;
        clk        = 1'b0;
        rst_n      = 1'b0;
        m0_wr      = '0;
        m0_awvalid = 1'b0;
        m0_wvalid  = 1'b0;
        m0_ar      = '0;
        m0_arvalid = 1'b0;
        m0_rready  = 1'b0;
        m1_wr      = '0;
        m1_awvalid = 1'b0;
        m1_wvalid  = 1'b0;
        m1_ar      = '0;
        m1_arvalid = 1'b0;
        m1_rready  = 1'b0;
        s_wr_ready = '0;
        s_arready  = '0;
        s_rvalid   = '1;  // stray slave rvalid must stay blocked
        for (int i = 0; i < SLAVE_COUNT; i++)
            s_rdata[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int c = 0; c < TEST_CYCLES; c++) begin
            @(posedge clk);
            #1;
            drive_masters();
            drive_slaves();
        end
        check_reached("reset with quiet outputs", n_reset);
        check_reached("write routing", n_write);
        check_reached("write priority", n_wr_prio);
        check_reached("read address priority", n_ar_prio);
        check_reached("write back-pressure", n_wr_bp);
        check_reached("read address back-pressure", n_ar_bp);
        check_reached("read return", n_read);
        if (missing != 0) begin
            $display("Verification failed");
            $fatal(1, "%0d behaviors were not reached", missing);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("simulation timed out before the test sequence finished");
        $display("Verification failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- verification/interconnect_props.sv
`timescale 1ns/1ns
`default_nettype none

module interconnect_props (
    input logic                     clk,
    input logic                     rst_n,
    input axi_lite_pkg::wr_req_t    m0_wr,
    input logic                     m0_awvalid,
    input logic                     m0_wvalid,
    input logic                     m0_awready,
    input logic                     m0_wready,
    input axi_lite_pkg::rd_req_t    m0_ar,
    input logic                     m0_arvalid,
    input logic                     m0_arready,
    input axi_lite_pkg::data_t      m0_rdata,
    input logic                     m0_rvalid,
    input logic                     m0_rready,
    input axi_lite_pkg::wr_req_t    m1_wr,
    input logic                     m1_awvalid,
    input logic                     m1_wvalid,
    input logic                     m1_awready,
    input logic                     m1_wready,
    input axi_lite_pkg::rd_req_t    m1_ar,
    input logic                     m1_arvalid,
    input logic                     m1_arready,
    input axi_lite_pkg::data_t      m1_rdata,
    input logic                     m1_rvalid,
    input logic                     m1_rready,
    input axi_lite_pkg::wr_req_t    s_wr_req [axi_lite_pkg::SLAVE_COUNT],
    input axi_lite_pkg::slave_sel_t s_wr_valid,
    input axi_lite_pkg::slave_sel_t s_wr_ready,
    input axi_lite_pkg::rd_req_t    s_ar_req [axi_lite_pkg::SLAVE_COUNT],
    input axi_lite_pkg::slave_sel_t s_arvalid,
    input axi_lite_pkg::slave_sel_t s_arready,
    input axi_lite_pkg::slave_sel_t s_rready
);
    import axi_lite_pkg::*;

    logic                           m0_full;  // address and data both offered
    logic                           m1_full;
    logic                           wr_any;
    wr_req_t                        wr_exp;   // write that should win
    logic [$clog2(SLAVE_COUNT)-1:0] wr_idx;
    logic [1:0]                     wr_win_ready;
    rd_req_t                        ar_exp;   // read address that should win
    logic [$clog2(SLAVE_COUNT)-1:0] ar_idx;
    logic                           ar_win_ready;
    logic [2*SLAVE_COUNT+7:0]       quiet_bits;
    logic                           rd_seen;
    logic                           rd_pend;  // accepted read still owes its data
    logic                           rd_owner; // high when m1 issued the last accepted read
    addr_t                          rd_addr;
    logic [$clog2(SLAVE_COUNT)-1:0] rd_idx;
    slave_sel_t                     rready_exp;

    assign m0_full      = m0_awvalid & m0_wvalid;
    assign m1_full      = m1_awvalid & m1_wvalid;
    assign wr_any       = m0_full | m1_full;
    assign wr_exp       = m0_full ? m0_wr : m1_wr;
    assign wr_idx       = wr_exp.addr[SEL_LSB +: $clog2(SLAVE_COUNT)];
    assign wr_win_ready = m0_full ? {m0_awready, m0_wready} : {m1_awready, m1_wready};
    assign ar_exp       = m0_arvalid ? m0_ar : m1_ar;
    assign ar_idx       = ar_exp.addr[SEL_LSB +: $clog2(SLAVE_COUNT)];
    assign ar_win_ready = m0_arvalid ? m0_arready : m1_arready;
    assign quiet_bits   = {s_wr_valid, s_arvalid,
                           m0_awready, m0_wready, m0_arready,
                           m1_awready, m1_wready, m1_arready,
                           m0_rvalid, m1_rvalid};
    assign rd_idx       = rd_addr[SEL_LSB +: $clog2(SLAVE_COUNT)];
    assign rready_exp   = (rd_pend && (rd_owner ? m1_rready : m0_rready)) ?
                          slave_sel_t'(1) << rd_idx : '0;

    // last accepted read address and who issued it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_seen  <= 1'b0;
            rd_pend  <= 1'b0;
            rd_owner <= 1'b0;
            rd_addr  <= '0;
        end else if (m0_arvalid && m0_arready) begin
            rd_seen  <= 1'b1;
            rd_pend  <= 1'b1;
            rd_owner <= 1'b0;
            rd_addr  <= m0_ar.addr;
        end else if (m1_arvalid && m1_arready) begin
            rd_seen  <= 1'b1;
            rd_pend  <= 1'b1;
            rd_owner <= 1'b1;
            rd_addr  <= m1_ar.addr;
        end else if ((m0_rvalid && m0_rready) || (m1_rvalid && m1_rready)) begin
            rd_pend  <= 1'b0;
        end
    end

    a_reset: assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> quiet_bits == '0)
        else $error("Fail %0t reset outputs got %h expected 0", $time, quiet_bits);

    a_wr_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wr_any |-> s_wr_valid == (slave_sel_t'(1) << wr_idx))
        else $error("Fail %0t s_wr_valid got %h expected %h", $time, s_wr_valid,
                    slave_sel_t'(1) << wr_idx);

    a_wr_req: assert property (@(posedge clk) disable iff (!rst_n)
        wr_any |-> s_wr_req[wr_idx] == wr_exp)
        else $error("Fail %0t s_wr_req got %h expected %h", $time, s_wr_req[wr_idx], wr_exp);

    a_wr_prio: assert property (@(posedge clk) disable iff (!rst_n)
        m0_full && m1_full |-> {m1_awready, m1_wready} == 2'b00)
        else $error("Fail %0t m1 awready/wready got %b expected 00", $time,
                    {m1_awready, m1_wready});

    a_wr_bp: assert property (@(posedge clk) disable iff (!rst_n)
        wr_any && !s_wr_ready[wr_idx] |-> wr_win_ready == 2'b00)
        else $error("Fail %0t winner awready/wready got %b expected 00", $time, wr_win_ready);

    a_ar_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_arvalid || m1_arvalid) |-> s_arvalid == (slave_sel_t'(1) << ar_idx))
        else $error("Fail %0t s_arvalid got %h expected %h", $time, s_arvalid,
                    slave_sel_t'(1) << ar_idx);

    a_ar_req: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_arvalid || m1_arvalid) |-> s_ar_req[ar_idx] == ar_exp)
        else $error("Fail %0t s_ar_req got %h expected %h", $time, s_ar_req[ar_idx], ar_exp);

    a_ar_prio: assert property (@(posedge clk) disable iff (!rst_n)
        m0_arvalid && m1_arvalid |-> !m1_arready)
        else $error("Fail %0t m1_arready got %b expected 0", $time, m1_arready);

    a_ar_bp: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_arvalid || m1_arvalid) && !s_arready[ar_idx] |-> !ar_win_ready)
        else $error("Fail %0t winner arready got %b expected 0", $time, ar_win_ready);

    a_rd_seen: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_rvalid || m1_rvalid) |-> rd_seen)
        else $error("read data reached a master before any read address was accepted");

    a_rd_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_rvalid || m1_rvalid) |-> {m0_rvalid, m1_rvalid} == {!rd_owner, rd_owner})
        else $error("Fail %0t m0/m1 rvalid got %b expected %b", $time,
                    $sampled({m0_rvalid, m1_rvalid}), $sampled({!rd_owner, rd_owner}));

    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_rvalid || m1_rvalid) |-> (m1_rvalid ? m1_rdata : m0_rdata) == ~rd_addr)
        else $error("Fail %0t rdata got %h expected %h", $time,
                    $sampled(m1_rvalid ? m1_rdata : m0_rdata), $sampled(~rd_addr));

    // rready of the owning master goes only to the slave that owes the data
    a_rready: assert property (@(posedge clk) disable iff (!rst_n)
        s_rready == rready_exp)
        else $error("Fail %0t s_rready got %h expected %h", $time,
                    $sampled(s_rready), $sampled(rready_exp));

endmodule

bind axi_lite_interconnect interconnect_props props (.*);

`default_nettype wire

//--- verilog/axi_lite_interconnect.sv
`timescale 1ns/1ns
`default_nettype none

module axi_lite_interconnect (
    input  logic                     clk,
    input  logic                     rst_n,
    // master 0, highest priority
    input  axi_lite_pkg::wr_req_t    m0_wr,
    input  logic                     m0_awvalid,
    output logic                     m0_awready,
    input  logic                     m0_wvalid,
    output logic                     m0_wready,
    input  axi_lite_pkg::rd_req_t    m0_ar,
    input  logic                     m0_arvalid,
    output logic                     m0_arready,
    output axi_lite_pkg::data_t      m0_rdata,
    output logic                     m0_rvalid,
    input  logic                     m0_rready,
    // master 1
    input  axi_lite_pkg::wr_req_t    m1_wr,
    input  logic                     m1_awvalid,
    output logic                     m1_awready,
    input  logic                     m1_wvalid,
    output logic                     m1_wready,
    input  axi_lite_pkg::rd_req_t    m1_ar,
    input  logic                     m1_arvalid,
    output logic                     m1_arready,
    output axi_lite_pkg::data_t      m1_rdata,
    output logic                     m1_rvalid,
    input  logic                     m1_rready,
    // slaves, indexed by the address nibble
    output axi_lite_pkg::wr_req_t    s_wr_req [axi_lite_pkg::SLAVE_COUNT],
    output axi_lite_pkg::slave_sel_t s_wr_valid,
    input  axi_lite_pkg::slave_sel_t s_wr_ready,
    output axi_lite_pkg::rd_req_t    s_ar_req [axi_lite_pkg::SLAVE_COUNT],
    output axi_lite_pkg::slave_sel_t s_arvalid,
    input  axi_lite_pkg::slave_sel_t s_arready,
    input  axi_lite_pkg::data_t      s_rdata [axi_lite_pkg::SLAVE_COUNT],
    input  axi_lite_pkg::slave_sel_t s_rvalid,
    output axi_lite_pkg::slave_sel_t s_rready
);
    import axi_lite_pkg::*;

    wr_req_t    wr_req;  // winning write request
    logic       wr_valid;
    logic       wr_ready;
    rd_req_t    ar_req;  // winning read address
    logic       ar_valid;
    logic       ar_ready;
    slave_sel_t ar_sel;  // decoded read target
    data_t      rdata;   // merged read return
    logic       rvalid;
    logic       rready;

    master_arbiter arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .m0_wr      (m0_wr),
        .m1_wr      (m1_wr),
        .m0_awvalid (m0_awvalid),
        .m0_wvalid  (m0_wvalid),
        .m1_awvalid (m1_awvalid),
        .m1_wvalid  (m1_wvalid),
        .m0_awready (m0_awready),
        .m0_wready  (m0_wready),
        .m1_awready (m1_awready),
        .m1_wready  (m1_wready),
        .m0_ar      (m0_ar),
        .m1_ar      (m1_ar),
        .m0_arvalid (m0_arvalid),
        .m1_arvalid (m1_arvalid),
        .m0_arready (m0_arready),
        .m1_arready (m1_arready),
        .m0_rdata   (m0_rdata),
        .m1_rdata   (m1_rdata),
        .m0_rvalid  (m0_rvalid),
        .m1_rvalid  (m1_rvalid),
        .m0_rready  (m0_rready),
        .m1_rready  (m1_rready),
        .wr_req     (wr_req),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .ar_req     (ar_req),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    slave_fanout #(.req_t(wr_req_t)) write_fanout (
        .req         (wr_req),
        .valid       (wr_valid),
        .slave_ready (s_wr_ready),
        .slave_req   (s_wr_req),
        .slave_valid (s_wr_valid),
        .ready       (wr_ready),
        .sel         ()  // write needs no return path
    );

    slave_fanout #(.req_t(rd_req_t)) ar_fanout (
        .req         (ar_req),
        .valid       (ar_valid),
        .slave_ready (s_arready),
        .slave_req   (s_ar_req),
        .slave_valid (s_arvalid),
        .ready       (ar_ready),
        .sel         (ar_sel)
    );

    read_return rd_return (
        .clk          (clk),
        .rst_n        (rst_n),
        .ar_sel       (ar_sel),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .rready       (rready),
        .slave_rdata  (s_rdata),
        .slave_rvalid (s_rvalid),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .slave_rready (s_rready)
    );

endmodule

`default_nettype wire

//--- verilog/master_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module master_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    // write request side of the masters
    input  axi_lite_pkg::wr_req_t m0_wr,
    input  axi_lite_pkg::wr_req_t m1_wr,
    input  logic                  m0_awvalid,
    input  logic                  m0_wvalid,
    input  logic                  m1_awvalid,
    input  logic                  m1_wvalid,
    output logic                  m0_awready,
    output logic                  m0_wready,
    output logic                  m1_awready,
    output logic                  m1_wready,
    // read address side of the masters
    input  axi_lite_pkg::rd_req_t m0_ar,
    input  axi_lite_pkg::rd_req_t m1_ar,
    input  logic                  m0_arvalid,
    input  logic                  m1_arvalid,
    output logic                  m0_arready,
    output logic                  m1_arready,
    // read data side of the masters
    output axi_lite_pkg::data_t   m0_rdata,
    output axi_lite_pkg::data_t   m1_rdata,
    output logic                  m0_rvalid,
    output logic                  m1_rvalid,
    input  logic                  m0_rready,
    input  logic                  m1_rready,
    // shared channels toward the slaves
    output axi_lite_pkg::wr_req_t wr_req,
    output logic                  wr_valid,
    input  logic                  wr_ready,
    output axi_lite_pkg::rd_req_t ar_req,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    input  axi_lite_pkg::data_t   rdata,
    input  logic                  rvalid,
    output logic                  rready
);
    import axi_lite_pkg::*;

    logic m0_wr_gnt;  // m0 owns the write path
    logic m1_wr_gnt;
    logic m0_ar_gnt;  // m0 owns the read address path
    logic m1_ar_gnt;
    logic m0_rown;    // m0 waits for read data
    logic m1_rown;

    // a write competes only once address and data are both present
    assign m0_wr_gnt = m0_awvalid & m0_wvalid;
    assign m1_wr_gnt = m1_awvalid & m1_wvalid & ~m0_wr_gnt;

    assign wr_req   = m0_wr_gnt ? m0_wr : m1_wr;
    assign wr_valid = m0_wr_gnt | m1_wr_gnt;

    assign m0_awready = m0_wr_gnt & wr_ready;
    assign m0_wready  = m0_wr_gnt & wr_ready;
    assign m1_awready = m1_wr_gnt & wr_ready;
    assign m1_wready  = m1_wr_gnt & wr_ready;

    // fixed priority on the read address channel, m0 first
    assign m0_ar_gnt = m0_arvalid;
    assign m1_ar_gnt = m1_arvalid & ~m0_arvalid;

    assign ar_req   = m0_ar_gnt ? m0_ar : m1_ar;
    assign ar_valid = m0_ar_gnt | m1_ar_gnt;

    assign m0_arready = m0_ar_gnt & ar_ready;
    assign m1_arready = m1_ar_gnt & ar_ready;

    // owner flags, set by address accept and cleared by the data handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m0_rown <= 1'b0;
            m1_rown <= 1'b0;
        end else begin
            if (m0_arvalid && m0_arready)
                m0_rown <= 1'b1;
            else if (m0_rvalid && m0_rready)
                m0_rown <= 1'b0;
            if (m1_arvalid && m1_arready)
                m1_rown <= 1'b1;
            else if (m1_rvalid && m1_rready)
                m1_rown <= 1'b0;
        end
    end

    assign m0_rdata  = m0_rown ? rdata : '0;
    assign m1_rdata  = m1_rown ? rdata : '0;
    assign m0_rvalid = m0_rown & rvalid;
    assign m1_rvalid = m1_rown & rvalid;
    assign rready    = (m0_rown & m0_rready) | (m1_rown & m1_rready);  // from the owner only

endmodule

`default_nettype wire

//--- verilog/read_return.sv
`timescale 1ns/1ns
`default_nettype none

module read_return (
    input  logic                     clk,
    input  logic                     rst_n,
    input  axi_lite_pkg::slave_sel_t ar_sel,
    input  logic                     ar_valid,
    input  logic                     ar_ready,
    input  logic                     rready,
    input  axi_lite_pkg::data_t      slave_rdata [axi_lite_pkg::SLAVE_COUNT],
    input  axi_lite_pkg::slave_sel_t slave_rvalid,
    output axi_lite_pkg::data_t      rdata,
    output logic                     rvalid,
    output axi_lite_pkg::slave_sel_t slave_rready
);
    import axi_lite_pkg::*;

    slave_sel_t rd_sel;  // slave that owes the pending read data

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel <= '0;
        end else if (ar_valid && ar_ready) begin
            rd_sel <= ar_sel;  // latch target on address accept
        end
    end

    // merge the data of the recorded slave
    always_comb begin
        rdata = '0;
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            if (rd_sel[i])
                rdata = rdata | slave_rdata[i];
        end
    end

    assign rvalid       = |(rd_sel & slave_rvalid);
    assign slave_rready = rd_sel & {SLAVE_COUNT{rready}};  // rready back to that slave only

endmodule

`default_nettype wire

//--- verilog/slave_fanout.sv
`timescale 1ns/1ns
`default_nettype none

module slave_fanout #(
    parameter type req_t = axi_lite_pkg::rd_req_t  // needs an addr field
) (
    input  req_t                    req,
    input  logic                    valid,
    input  axi_lite_pkg::slave_sel_t slave_ready,
    output req_t                    slave_req [axi_lite_pkg::SLAVE_COUNT],
    output axi_lite_pkg::slave_sel_t slave_valid,
    output logic                    ready,
    output axi_lite_pkg::slave_sel_t sel
);
    import axi_lite_pkg::*;

    // one-hot decode of the slave nibble
    always_comb begin
        sel = '0;
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            if (req.addr[SEL_LSB +: $clog2(SLAVE_COUNT)] == i)
                sel[i] = 1'b1;
        end
    end

    assign slave_valid = sel & {SLAVE_COUNT{valid}};  // only the target sees valid
    assign ready       = |(sel & slave_ready);  // ready of the addressed slave

    // payload goes to every slave unchanged
    always_comb begin
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            slave_req[i] = req;
        end
    end

endmodule

`default_nettype wire

//--- verilog/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    localparam int ADDR_W      = 32;  // byte address
    localparam int DATA_W      = 32;  // bus word
    localparam int STRB_W      = DATA_W / 8;  // one strobe per byte lane
    localparam int SLAVE_COUNT = 16;
    localparam int SEL_LSB     = 28;  // top nibble picks the slave

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [STRB_W-1:0]      strb_t;
    typedef logic [SLAVE_COUNT-1:0] slave_sel_t;  // one bit per slave

    // write address and write data always move together on the slave side
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

    // read address channel payload
    typedef struct packed {
        addr_t addr;
    } rd_req_t;

endpackage

`default_nettype wire
